// File: Makefile
# Verilator build and run for the data bus receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_data_bus_receive
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(wildcard hdl/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_os_model.svh
// Ordered set reference model
`ifndef TB_OS_MODEL_SVH
`define TB_OS_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

////////////////////////////////////////
// pattern table
////////////////////////////////////////

// whole set for one lane, width 0 for a code that is not detected
function automatic logic [63:0] set_pattern(input int lane, input os_code_t code,
		output int width);
	logic [63:0] pat;
	pat   = '0;
	width = 32;                                   // gen4 header
	case (code)
		GEN3_TS1: begin
			pat   = 64'h01000000040098F2;
			width = 64;
		end
		GEN3_TS2: begin
			pat   = 64'h01000000040064F2;
			width = 64;
		end
		GEN4_TS2: pat = 64'h7E04B0F0;
		GEN4_TS3: pat = 64'h7E0690F0;
		GEN4_TS4: pat = 64'h7E0F0F00;
		default:  width = 0;
	endcase
	if (width == 64) begin
		pat[55:48] = 8'(lane);                    // lane number byte
	end
	return pat;
endfunction

////////////////////////////////////////
// expected hits
////////////////////////////////////////

// counts the sets a lane reports for a byte sequence
function automatic int count_hits(input int lane, input os_code_t code, input byte_q_t bytes);
	logic [63:0] pat;
	logic [63:0] mask;
	logic [63:0] win;
	logic [7:0]  start;
	int          width;
	int          nbits;
	int          hits;
	bit          armed;
	pat   = set_pattern(lane, code, width);
	hits  = 0;
	nbits = 0;
	armed = 1'b0;
	win   = '0;
	if (width == 0) begin
		return 0;
	end
	mask  = ~64'h0 >> (64 - width);
	start = 8'(pat >> (width - 8));               // first byte of the set
	for (int i = 0; i < bytes.size(); i++) begin
		if (!armed && bytes[i] == start) begin
			armed = 1'b1;
			win   = '0;
			nbits = 0;
		end
		for (int b = 7; b >= 0; b--) begin
			if (armed) begin
				win = {win[62:0], bytes[i][b]};   // msb first
				nbits++;
				if (nbits >= width && (win & mask) == pat) begin
					hits++;
					// a set that follows directly keeps the lane armed
					armed = (i + 1 < bytes.size()) && (bytes[i + 1] == start);
				end
			end
		end
	end
	return hits;
endfunction

// fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

// File: bench/tb_data_bus_receive.sv
// Data bus receiver testbench
`timescale 1ns/1ps

module tb_data_bus_receive import rx_pkg::*; ();

`include "tb_os_model.svh"

	logic              fsm_clk = 1'b0;
	logic              rst;
	logic              data_os;
	os_code_t          d_sel;
	logic              lane_rx_on;
	logic [BYTE_W-1:0] lane_0_rx;
	logic [BYTE_W-1:0] lane_1_rx;
	logic [BYTE_W-1:0] transport_layer_data_out;
	os_code_t          os_in_l0;
	os_code_t          os_in_l1;

	byte_q_t     tx0;           // bytes waiting for lane 0
	byte_q_t     tx1;           // bytes waiting for lane 1
	int          phase;         // clocks since the last byte boundary
	logic [15:0] lfsr_state;
	int          errors;        // test process failures
	int          cmp_errors;    // compare process failures
	int          tests;
	int          hits_l0;
	int          hits_l1;
	logic        fwd_q;         // forwarding condition of the last edge
	logic [7:0]  lane0_q;       // lane 0 byte of the last edge

	data_bus_receive #(
		.LANE0_ID (0),
		.LANE1_ID (1)
	) u_dut (
		.fsm_clk                  (fsm_clk),
		.rst                      (rst),
		.data_os                  (data_os),
		.d_sel                    (d_sel),
		.lane_rx_on               (lane_rx_on),
		.lane_0_rx                (lane_0_rx),
		.lane_1_rx                (lane_1_rx),
		.transport_layer_data_out (transport_layer_data_out),
		.os_in_l0                 (os_in_l0),
		.os_in_l1                 (os_in_l1)
	);

	initial begin
		forever #50 fsm_clk = ~fsm_clk;          // 100 ns period
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	function automatic int check_code(input string name, input os_code_t got,
			input os_code_t exp);
		int bad;
		bad = 0;
		assert (got == exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			bad = 1;
		end
		return bad;
	endfunction

	function automatic int check_int(input string name, input int got, input int exp);
		int bad;
		bad = 0;
		assert (got == exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			bad = 1;
		end
		return bad;
	endfunction

	// outputs sampled before the edge updates them
	always @(posedge fsm_clk) begin
		if (rst) begin
			if (fwd_q) begin
				cmp_errors += check_int("transport_layer_data_out",
					int'(transport_layer_data_out), int'(lane0_q));
				cmp_errors += check_code("os_in_l0", os_in_l0, TRANSPORT);
				cmp_errors += check_code("os_in_l1", os_in_l1, NONE);
			end else begin
				if (os_in_l0 != NONE) begin
					hits_l0++;
					cmp_errors += check_code("os_in_l0", os_in_l0, d_sel);
				end
				if (os_in_l1 != NONE) begin
					hits_l1++;
					cmp_errors += check_code("os_in_l1", os_in_l1, d_sel);
				end
			end
			fwd_q   = data_os && (d_sel == TRANSPORT) && lane_rx_on;
			lane0_q = lane_0_rx;
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// one lfsr step per bit taken
	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b          = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	// random byte that can never arm a detector
	function automatic logic [7:0] quiet_byte();
		logic [7:0] b;
		b = random_byte();
		while (b == 8'h01 || b == 8'h7E)
			b = random_byte();
		return b;
	endfunction

	// one clock, new lane bytes every eighth falling edge
	task automatic step_clock();
		@(negedge fsm_clk);
		if (phase == 0) begin
			lane_0_rx = 8'h00;                   // idle filler
			lane_1_rx = 8'h00;
			if (tx0.size() > 0)
				lane_0_rx = tx0.pop_front();
			if (tx1.size() > 0)
				lane_1_rx = tx1.pop_front();
		end
		phase = (phase + 1) % 8;
	endtask

	task automatic select_mode(input os_code_t code, input logic xport);
		step_clock();
		d_sel   = code;
		data_os = xport;
		repeat (BYTE_W) step_clock();            // detectors settle
	endtask

	// whole ordered set for lane_id, queued on lane lane_sel
	task automatic queue_set(input int lane_sel, input int lane_id, input os_code_t code);
		logic [63:0] pat;
		int          width;
		pat = set_pattern(lane_id, code, width);
		for (int i = width / 8 - 1; i >= 0; i--) begin
			if (lane_sel == 0)
				tx0.push_back(pat[i*8 +: 8]);
			else
				tx1.push_back(pat[i*8 +: 8]);
		end
	endtask

	// sends both queues and compares the hit counts with the model
	task automatic send_and_check(input os_code_t code);
		int exp0;
		int exp1;
		int base0;
		int base1;
		int n;
		exp0  = count_hits(0, code, tx0);
		exp1  = count_hits(1, code, tx1);
		base0 = hits_l0;
		base1 = hits_l1;
		while (tx0.size() > 0 || tx1.size() > 0)
			step_clock();
		n = 0;
		while ((hits_l0 - base0 < exp0 || hits_l1 - base1 < exp1) && n < 40) begin
			step_clock();
			n++;
		end
		assert (hits_l0 - base0 >= exp0 && hits_l1 - base1 >= exp1) else begin
			$display("expected ordered set hits did not arrive within 40 clocks");
			errors++;
		end
		repeat (24) step_clock();                // room for a stray hit
		errors += check_int("os_in_l0 hits", hits_l0 - base0, exp0);
		errors += check_int("os_in_l1 hits", hits_l1 - base1, exp1);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors + cmp_errors == err_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: failed", tests, name);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int       err_before;
		int       other;
		os_code_t codes[5];
		rst          = 1'b0;
		data_os      = 1'b0;
		d_sel        = NONE;
		lane_rx_on   = 1'b0;
		lane_0_rx    = 8'h00;
		lane_1_rx    = 8'h00;
		phase        = 0;
		lfsr_state   = 16'd74;
		errors       = 0;
		cmp_errors   = 0;
		tests        = 0;
		hits_l0      = 0;
		hits_l1      = 0;
		fwd_q        = 1'b0;
		lane0_q      = 8'h00;
		codes        = '{GEN3_TS1, GEN3_TS2, GEN4_TS2, GEN4_TS3, GEN4_TS4};

		repeat (10) @(negedge fsm_clk);
		rst        = 1'b1;
		err_before = errors + cmp_errors;
		@(negedge fsm_clk);
		errors += check_code("os_in_l0", os_in_l0, NONE);
		errors += check_code("os_in_l1", os_in_l1, NONE);
		errors += check_int("transport_layer_data_out", int'(transport_layer_data_out), 0);
		finish_test("reset state", err_before);

		@(negedge fsm_clk);
		lane_rx_on = 1'b1;                       // first byte boundary
		phase      = 1;

		err_before = errors + cmp_errors;
		select_mode(GEN3_TS1, 1'b0);
		queue_set(0, 0, GEN3_TS1);
		queue_set(0, 0, GEN3_TS1);
		queue_set(1, 1, GEN3_TS1);
		queue_set(1, 1, GEN3_TS1);
		send_and_check(GEN3_TS1);
		queue_set(0, 0, GEN3_TS1);
		queue_set(1, 0, GEN3_TS1);               // lane 0 set on lane 1
		send_and_check(GEN3_TS1);
		finish_test("gen3 ts1", err_before);

		err_before = errors + cmp_errors;
		select_mode(GEN3_TS2, 1'b0);
		queue_set(0, 0, GEN3_TS2);
		queue_set(1, 1, GEN3_TS2);
		send_and_check(GEN3_TS2);
		select_mode(GEN3_TS1, 1'b0);
		queue_set(0, 0, GEN3_TS2);
		queue_set(1, 1, GEN3_TS2);
		send_and_check(GEN3_TS1);
		finish_test("gen3 ts2 and wrong selection", err_before);

		err_before = errors + cmp_errors;
		for (int k = 2; k < 5; k++) begin
			other = (k == 4) ? 2 : k + 1;
			select_mode(codes[k], 1'b0);
			queue_set(0, 0, codes[k]);
			queue_set(1, 1, codes[k]);
			send_and_check(codes[k]);
			queue_set(0, 0, codes[other]);
			queue_set(1, 1, codes[other]);
			send_and_check(codes[k]);
		end
		finish_test("gen4 headers", err_before);

		err_before = errors + cmp_errors;
		select_mode(TRANSPORT, 1'b1);
		for (int k = 0; k < 16; k++)
			tx0.push_back(random_byte());
		send_and_check(TRANSPORT);
		select_mode(NONE, 1'b0);
		finish_test("transport forwarding", err_before);

		err_before = errors + cmp_errors;
		for (int k = 0; k < 5; k++) begin
			select_mode(codes[k], 1'b0);
			for (int j = 0; j < 12; j++) begin
				tx0.push_back(quiet_byte());
				tx1.push_back(quiet_byte());
			end
			send_and_check(codes[k]);
		end
		finish_test("random traffic", err_before);

		$display("tests run %0d, errors %0d", tests, errors + cmp_errors);
		if (errors + cmp_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+bench
hdl/rx_pkg.sv
hdl/lane_serializer.sv
hdl/os_pattern_match.sv
hdl/os_lane_detector.sv
hdl/rx_mode_ctrl.sv
hdl/data_bus_receive.sv
bench/tb_data_bus_receive.sv

// File: hdl/data_bus_receive.sv
// Two-lane data bus receiver
`timescale 1ns/1ps

module data_bus_receive import rx_pkg::*; #(
	parameter int LANE0_ID = 0,
	parameter int LANE1_ID = 1
) (
	input  logic              fsm_clk,
	input  logic              rst,
	input  logic              data_os,
	input  os_code_t          d_sel,
	input  logic              lane_rx_on,
	input  logic [BYTE_W-1:0] lane_0_rx,
	input  logic [BYTE_W-1:0] lane_1_rx,
	output logic [BYTE_W-1:0] transport_layer_data_out,
	output os_code_t          os_in_l0,
	output os_code_t          os_in_l1
);

	logic     transport_mode;
	logic     detect_en;
	os_code_t transport_code;
	logic     ser_bit_l0;
	logic     ser_bit_l1;
	logic     byte_load_l0;
	logic     byte_load_l1;
	os_code_t det_code_l0;   // lane 0 detector result

	////////////////////////////////////////
	// mode control
	////////////////////////////////////////

	rx_mode_ctrl u_mode (
		.fsm_clk                  (fsm_clk),
		.rst                      (rst),
		.data_os                  (data_os),
		.d_sel                    (d_sel),
		.lane_rx_on               (lane_rx_on),
		.lane_0_rx                (lane_0_rx),
		.byte_load                (byte_load_l0),
		.transport_mode           (transport_mode),
		.detect_en                (detect_en),
		.transport_layer_data_out (transport_layer_data_out),
		.transport_code           (transport_code)
	);

	////////////////////////////////////////
	// lane 0
	////////////////////////////////////////

	lane_serializer u_ser_l0 (
		.fsm_clk    (fsm_clk),
		.rst        (rst),
		.lane_rx_on (lane_rx_on),
		.lane_rx    (lane_0_rx),
		.ser_bit    (ser_bit_l0),
		.byte_load  (byte_load_l0)
	);

	os_lane_detector #(
		.LANE_ID (LANE0_ID)
	) u_det_l0 (
		.fsm_clk        (fsm_clk),
		.rst            (rst),
		.d_sel          (d_sel),
		.detect_en      (detect_en),
		.transport_mode (transport_mode),
		.lane_rx        (lane_0_rx),
		.ser_bit        (ser_bit_l0),
		.byte_load      (byte_load_l0),
		.os_code        (det_code_l0)
	);

	////////////////////////////////////////
	// lane 1
	////////////////////////////////////////

	lane_serializer u_ser_l1 (
		.fsm_clk    (fsm_clk),
		.rst        (rst),
		.lane_rx_on (lane_rx_on),
		.lane_rx    (lane_1_rx),
		.ser_bit    (ser_bit_l1),
		.byte_load  (byte_load_l1)
	);

	os_lane_detector #(
		.LANE_ID (LANE1_ID)
	) u_det_l1 (
		.fsm_clk        (fsm_clk),
		.rst            (rst),
		.d_sel          (d_sel),
		.detect_en      (detect_en),
		.transport_mode (transport_mode),
		.lane_rx        (lane_1_rx),
		.ser_bit        (ser_bit_l1),
		.byte_load      (byte_load_l1),
		.os_code        (os_in_l1)   // NONE while forwarding
	);

	// lane 0 carries the transport indication
	assign os_in_l0 = transport_mode ? transport_code : det_code_l0;

endmodule

// File: hdl/lane_serializer.sv
// Lane byte serializer
`timescale 1ns/1ps

module lane_serializer import rx_pkg::*; (
	input  logic              fsm_clk,
	input  logic              rst,
	input  logic              lane_rx_on,
	input  logic [BYTE_W-1:0] lane_rx,
	output logic              ser_bit,
	output logic              byte_load
);

	localparam int PHASE_W = $clog2(BYTE_W);

	logic [PHASE_W-1:0] phase;  // bit position inside the byte
	logic [BYTE_W-1:0]  shreg;  // byte being shifted out

	// first clock after lane_rx_on, then every byte
	assign byte_load = lane_rx_on && (phase == '0);

	////////////////////////////////////////
	// phase counter and output bit
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			phase   <= '0;
			ser_bit <= 1'b0;
		end else if (lane_rx_on) begin
			phase   <= phase + 1'b1;          // wraps at byte end
			ser_bit <= shreg[BYTE_W-1];       // msb first
		end else begin
			phase   <= '0;                    // realign on next start
		end
	end

	////////////////////////////////////////
	// parallel load, shift left
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			shreg <= '0;
		end else if (byte_load) begin
			shreg <= lane_rx;
		end else if (lane_rx_on) begin
			shreg <= {shreg[BYTE_W-2:0], 1'b0};
		end
	end

endmodule

// File: hdl/os_lane_detector.sv
// Per-lane ordered set detector
`timescale 1ns/1ps

module os_lane_detector import rx_pkg::*; #(
	parameter int LANE_ID = 0
) (
	input  logic              fsm_clk,
	input  logic              rst,
	input  os_code_t          d_sel,
	input  logic              detect_en,
	input  logic              transport_mode,
	input  logic [BYTE_W-1:0] lane_rx,
	input  logic              ser_bit,
	input  logic              byte_load,
	output os_code_t          os_code
);

	logic [GEN3_OS_W-1:0] exp_gen3;
	logic [GEN4_OS_W-1:0] exp_gen4;
	logic [BYTE_W-1:0]    start_sym;
	logic                 is_gen3;
	logic                 is_gen4;
	os_code_t             dsel_q;      // selection of last clock
	logic                 start_flag;
	logic                 sel_clear;
	logic                 shift_on;
	logic                 restart;
	logic                 hit_gen3;
	logic                 hit_gen4;
	logic                 match_now;
	logic                 end_of_set;

	////////////////////////////////////////
	// pattern selection
	////////////////////////////////////////

	always_comb begin
		exp_gen3 = GEN3_TS1_BASE;
		exp_gen4 = GEN4_TS2_HEAD;
		is_gen3  = 1'b0;
		is_gen4  = 1'b0;
		case (d_sel)
			GEN3_TS1: is_gen3 = 1'b1;
			GEN3_TS2: begin
				is_gen3  = 1'b1;
				exp_gen3 = GEN3_TS2_BASE;
			end
			GEN4_TS2: is_gen4 = 1'b1;
			GEN4_TS3: begin
				is_gen4  = 1'b1;
				exp_gen4 = GEN4_TS3_HEAD;
			end
			GEN4_TS4: begin
				is_gen4  = 1'b1;
				exp_gen4 = GEN4_TS4_HEAD;
			end
			default: ;                             // transport, none
		endcase
		exp_gen3[GEN3_LANE_MSB -: BYTE_W] = BYTE_W'(LANE_ID);  // lane number byte
	end

	assign start_sym  = is_gen3 ? GEN3_START : GEN4_START;
	assign restart    = (lane_rx == start_sym);
	assign sel_clear  = (d_sel != dsel_q) || !(is_gen3 || is_gen4) || transport_mode;
	assign shift_on   = start_flag && detect_en && !sel_clear;
	assign match_now  = shift_on && ((is_gen3 && hit_gen3) || (is_gen4 && hit_gen4));
	assign end_of_set = match_now && !restart;  // no set follows directly

	////////////////////////////////////////
	// matchers
	////////////////////////////////////////

	os_pattern_match #(
		.PATTERN_W (GEN3_OS_W)
	) u_match_gen3 (
		.fsm_clk  (fsm_clk),
		.rst      (rst),
		.clear    (sel_clear || end_of_set || !is_gen3),
		.shift_en (shift_on && is_gen3),
		.ser_bit  (ser_bit),
		.expected (exp_gen3),
		.hit      (hit_gen3)
	);

	os_pattern_match #(
		.PATTERN_W (GEN4_OS_W)
	) u_match_gen4 (
		.fsm_clk  (fsm_clk),
		.rst      (rst),
		.clear    (sel_clear || end_of_set || !is_gen4),
		.shift_en (shift_on && is_gen4),
		.ser_bit  (ser_bit),
		.expected (exp_gen4),
		.hit      (hit_gen4)
	);

	////////////////////////////////////////
	// start flag and code register
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			dsel_q     <= NONE;
			start_flag <= 1'b0;
			os_code    <= NONE;
		end else begin
			dsel_q <= d_sel;
			if (sel_clear) begin
				start_flag <= 1'b0;
			end else if (byte_load && restart) begin
				start_flag <= 1'b1;                  // start symbol seen
			end else if (end_of_set) begin
				start_flag <= 1'b0;
			end
			os_code <= match_now ? d_sel : NONE;     // one clock pulse
		end
	end

endmodule

// File: hdl/os_pattern_match.sv
// Serial pattern matcher
`timescale 1ns/1ps

module os_pattern_match #(
	parameter int PATTERN_W = 64
) (
	input  logic                 fsm_clk,
	input  logic                 rst,
	input  logic                 clear,
	input  logic                 shift_en,
	input  logic                 ser_bit,
	input  logic [PATTERN_W-1:0] expected,
	output logic                 hit
);

	logic [PATTERN_W-1:0] window;  // last PATTERN_W bits received

	////////////////////////////////////////
	// shift window
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			window <= '0;
		end else if (clear) begin
			window <= '0;                                // clear wins over shift
		end else if (shift_en) begin
			window <= {window[PATTERN_W-2:0], ser_bit};  // oldest bit ends up on top
		end
	end

	// all-zero window never equals a real pattern
	assign hit = (window == expected);

endmodule

// File: hdl/rx_mode_ctrl.sv
// Receiver mode control
`timescale 1ns/1ps

module rx_mode_ctrl import rx_pkg::*; (
	input  logic              fsm_clk,
	input  logic              rst,
	input  logic              data_os,
	input  os_code_t          d_sel,
	input  logic              lane_rx_on,
	input  logic [BYTE_W-1:0] lane_0_rx,
	input  logic              byte_load,
	output logic              transport_mode,
	output logic              detect_en,
	output logic [BYTE_W-1:0] transport_layer_data_out,
	output os_code_t          transport_code
);

	logic fwd_now;  // forwarding condition this clock

	assign fwd_now = data_os && (d_sel == TRANSPORT) && lane_rx_on;

	////////////////////////////////////////
	// transport path
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			transport_mode           <= 1'b0;
			transport_layer_data_out <= '0;
		end else begin
			transport_mode <= fwd_now;
			if (fwd_now) begin
				transport_layer_data_out <= lane_0_rx;  // byte of this edge
			end
		end
	end

	// follows the registered mode, so it lines up with the data
	assign transport_code = transport_mode ? TRANSPORT : NONE;

	////////////////////////////////////////
	// detect enable
	////////////////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			detect_en <= 1'b0;
		end else if (!lane_rx_on) begin
			detect_en <= 1'b0;                        // lane switched off
		end else if (byte_load) begin
			detect_en <= 1'b1;                        // first byte boundary
		end
	end

endmodule

// File: hdl/rx_pkg.sv
// Receiver shared definitions
package rx_pkg;

	////////////////////////////////////////
	// ordered set codes
	////////////////////////////////////////

	// codes 0, 1 and 4 are not used by this receiver
	typedef enum logic [3:0] {
		GEN3_TS1  = 4'h2,  // gen3 training set 1
		GEN3_TS2  = 4'h3,  // gen3 training set 2
		GEN4_TS2  = 4'h5,  // gen4 header, ts2
		GEN4_TS3  = 4'h6,  // gen4 header, ts3
		GEN4_TS4  = 4'h7,  // gen4 header, ts4
		TRANSPORT = 4'h8,  // transport data forwarding
		NONE      = 4'h9   // idle, nothing seen
	} os_code_t;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int BYTE_W    = 8;   // one lane byte
	localparam int GEN3_OS_W = 64;  // full gen3 set
	localparam int GEN4_OS_W = 32;  // gen4 header only

	////////////////////////////////////////
	// patterns
	////////////////////////////////////////

	// lane number byte sits second from the top, zero here
	localparam logic [GEN3_OS_W-1:0] GEN3_TS1_BASE = 64'h01000000040098F2;
	localparam logic [GEN3_OS_W-1:0] GEN3_TS2_BASE = 64'h01000000040064F2;

	// msb of the lane number field inside a gen3 set
	localparam int GEN3_LANE_MSB = GEN3_OS_W - BYTE_W - 1;

	// same header on every lane
	localparam logic [GEN4_OS_W-1:0] GEN4_TS2_HEAD = 32'h7E04B0F0;
	localparam logic [GEN4_OS_W-1:0] GEN4_TS3_HEAD = 32'h7E0690F0;
	localparam logic [GEN4_OS_W-1:0] GEN4_TS4_HEAD = 32'h7E0F0F00;

	////////////////////////////////////////
	// start symbols
	////////////////////////////////////////

	localparam logic [BYTE_W-1:0] GEN3_START = 8'h01;  // first byte of a gen3 set
	localparam logic [BYTE_W-1:0] GEN4_START = 8'h7E;  // first byte of a gen4 set

endpackage
